//--- Bender.yml
package:
  name: exec_unit

sources:
  # Shared package first, then the RTL blocks bottom-up
  - common/exec_pkg.sv
  - exec_unit/mac_pipe.sv
  - exec_unit/ldst_unit.sv
  - exec_unit/wb_select.sv
  - exec_unit/exec_unit.sv

  # Simulation only
  - target: test
    files:
      - dv/exec_unit_asserts.sv
      - dv/tb_exec_unit.sv

//--- common/exec_pkg.sv
// Execution unit shared definitions
// Widths, opcode encoding and the packed structs passed between
// the issue stage, the multiply-add pipeline, the load/store unit
// and the write-back port

package exec_pkg;

	localparam int DATA_W  = 32;	// Operand and result width
	localparam int IDX_W   = 5;	// Register file index
	localparam int ISSUE_W = 6;	// Issue number, wraps around

	typedef logic [DATA_W-1:0]  data_t;
	typedef logic [IDX_W-1:0]   index_t;
	typedef logic [ISSUE_W-1:0] issue_no_t;

	//////////////////////////////////////////////////
	// Opcodes
	typedef enum logic [2:0] {
		op_madd  = 3'd0,	// a * b + c
		op_mul   = 3'd1,	// a * b
		op_add   = 3'd2,	// a + b
		op_load  = 3'd3,	// Address a + b
		op_store = 3'd4	// Address a + b, data c
	} exec_op_e;

	//////////////////////////////////////////////////
	// Command from the issue stage, 110 bits
	typedef struct packed {
		exec_op_e  op;
		index_t    dst;
		issue_no_t issue_no;
		data_t     src1;
		data_t     src2;
		data_t     src3;
	} exec_cmd_t;

	// Write-back entry, 43 bits
	typedef struct packed {
		index_t    dst;
		data_t     data;
		issue_no_t issue_no;
	} wb_t;

	// Memory port request, 65 bits
	typedef struct packed {
		logic  we;	// Store when set
		data_t addr;
		data_t wdata;
	} mem_req_t;

endpackage

//--- dv/exec_unit_asserts.sv
`timescale 1ns/1ps
// Execution unit protocol assertions
// Bound into the execution unit. Covers the memory request
// handshake, a known write-back valid, dropped requests while
// busy and the output levels during reset

module exec_unit_asserts (
	input logic               clock,
	input logic               rst_n,
	input logic               busy,
	input logic               req,	// Issue strobe before gating
	input logic               frozen,	// Pipe held on a lost write-back
	input logic               pipe_head,	// First pipeline stage valid
	input logic               mem_req,
	input logic               mem_grant,
	input exec_pkg::mem_req_t mem,
	input logic               wb_valid
);

	//////////////////////////////////////////////////
	// Memory port
	property mem_req_held;
		@(posedge clock) disable iff (!rst_n)
		mem_req && !mem_grant |=> mem_req && $stable(mem);
	endproperty

	assert property (mem_req_held)
		else $error("mem_req dropped or mem changed before grant");

	//////////////////////////////////////////////////
	// Write-back and issue
	assert property (@(posedge clock) disable iff (!rst_n) !$isunknown(wb_valid))
		else $error("wb_valid is unknown out of reset");

	// A dropped request starts no memory access and leaves the
	// first pipeline stage empty unless the pipe is held
	assert property (@(posedge clock) disable iff (!rst_n)
		req && busy |=> !$rose(mem_req) && (!pipe_head || $past(frozen)))
		else $error("request accepted while busy");

	assert property (@(posedge clock) !rst_n |-> !wb_valid && !mem_req && !busy)
		else $error("outputs active during reset");

endmodule

bind exec_unit exec_unit_asserts u_asserts (
	.clock     (clock),
	.rst_n     (rst_n),
	.busy      (busy),
	.req       (req),
	.frozen    (frozen),
	.pipe_head (u_mac_pipe.stg_valid[0]),
	.mem_req   (mem_req),
	.mem_grant (mem_grant),
	.mem       (mem),
	.wb_valid  (wb_valid)
);

//--- dv/tb_exec_unit.sv
`timescale 1ns/1ps
// Execution unit testbench
// Directed tests for reset levels, arithmetic latency, store then
// load, age-ordered write-back and requests dropped while busy,
// against a behavioural memory of 256 words

module tb_exec_unit;

	import exec_pkg::*;

	localparam int MAC_DEPTH  = 4;
	localparam int MAX_CYCLES = 2000;	// All tests together run under 200 cycles

	logic      clock;
	logic      rst_n;
	logic      req;
	exec_cmd_t cmd;
	issue_no_t cur_issue_no;
	logic      mem_grant;
	logic      mem_end;
	data_t     mem_rdata;
	logic      busy;
	logic      mem_req;
	mem_req_t  mem;
	logic      wb_valid;
	wb_t       wb;
	logic      ls_done;

	data_t     mem_array [256];
	int        grant_delay;	// Cycles from mem_req seen to grant
	int        end_delay;	// Extra cycles from grant to mem_end
	int        access_count;
	int        done_count;
	int        cycle = 0;
	int        errors;
	int        checks;
	int        test_errors;
	issue_no_t next_issue;
	wb_t       wb_log [$];	// Every write-back seen, in order
	int        wb_cyc_log [$];

	exec_unit #(.MAC_DEPTH(MAC_DEPTH)) DUT (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (cycle >= MAX_CYCLES) begin
			$display("ERROR: run stopped after %0d cycles waiting for the DUT", MAX_CYCLES);
			$display("test failed");
			$finish;
		end
	end

	// Outputs are settled mid-cycle
	always @(negedge clock) begin
		if (rst_n && wb_valid) begin
			wb_log.push_back(wb);
			wb_cyc_log.push_back(cycle);
		end
		if (rst_n && ls_done) begin
			done_count++;
		end
	end

	//////////////////////////////////////////////////
	// Memory model
	initial begin : memory_model
		mem_req_t seen;
		forever begin
			@(posedge clock);
			#1;
			if (mem_req) begin
				seen = mem;
				access_count++;
				check_eq(seen.addr[31:8], 0, "memory address range");
				repeat (grant_delay) begin
					@(posedge clock);
					#1;
				end
				mem_grant = 1'b1;	// Sampled with mem_req on the next edge
				@(posedge clock);
				#1;
				mem_grant = 1'b0;
				if (seen.we) begin
					mem_array[seen.addr[7:0]] = seen.wdata;
				end
				repeat (end_delay) begin
					@(posedge clock);
					#1;
				end
				mem_rdata = mem_array[seen.addr[7:0]];
				mem_end   = 1'b1;
				@(posedge clock);
				#1;
				mem_end = 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	task automatic step();
		@(posedge clock);
		#1;
	endtask

	task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		checks++;
		if (actual !== expected) begin
			$display("FAIL %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
			errors++;
			test_errors++;
		end
	endtask

	task automatic report(input string name);
		if (test_errors == 0) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	// Holds req for one cycle
	task automatic send(input exec_op_e op, input index_t dst, input issue_no_t issue,
			input data_t a, input data_t b, input data_t c);
		req          = 1'b1;
		cmd.op       = op;
		cmd.dst      = dst;
		cmd.issue_no = issue;
		cmd.src1     = a;
		cmd.src2     = b;
		cmd.src3     = c;
		step();
		req = 1'b0;
	endtask

	task automatic wait_idle();
		@(negedge clock);
		while (busy) begin
			@(negedge clock);
		end
		step();
	endtask

	function automatic data_t arith_result(exec_op_e op, data_t a, data_t b, data_t c);
		case (op)
			op_madd: return a * b + c;
			op_mul:  return a * b;
			default: return a + b;
		endcase
	endfunction

	function automatic wb_t make_wb(input index_t dst, input data_t data, input issue_no_t issue);
		wb_t entry;
		entry.dst      = dst;
		entry.data     = data;
		entry.issue_no = issue;
		return entry;
	endfunction

	//////////////////////////////////////////////////
	// Tests
	task automatic reset_values();
		@(negedge clock);
		check_eq(wb_valid, 0, "wb_valid after reset");
		check_eq(mem_req, 0, "mem_req after reset");
		check_eq(busy, 0, "busy after reset");
		check_eq(ls_done, 0, "ls_done after reset");
		report("reset_values");
	endtask

	task automatic arith_stream();
		exec_op_e op;
		index_t   dst;
		data_t    a;
		data_t    b;
		data_t    c;
		wb_t      exp_wb [$];
		int       exp_cyc [$];
		wb_log.delete();
		wb_cyc_log.delete();
		wait_idle();
		for (int i = 0; i < 20; i++) begin
			op  = exec_op_e'($urandom_range(0, 2));
			dst = index_t'($urandom);
			a   = $urandom;
			b   = $urandom;
			c   = $urandom;
			exp_wb.push_back(make_wb(dst, arith_result(op, a, b, c), next_issue));
			exp_cyc.push_back(cycle + MAC_DEPTH);
			cur_issue_no = next_issue;
			send(op, dst, next_issue, a, b, c);
			next_issue++;
		end
		while (wb_log.size() < 20) begin
			step();
		end
		repeat (3) step();
		check_eq(wb_log.size(), 20, "arithmetic write-back count");
		for (int i = 0; i < 20 && i < wb_log.size(); i++) begin
			check_eq(wb_cyc_log[i], exp_cyc[i], "arithmetic write-back cycle");
			check_eq(wb_log[i], exp_wb[i], "arithmetic write-back");
		end
		report("arith_stream");
	endtask

	task automatic store_load();
		data_t     addr;
		data_t     a;
		data_t     value;
		index_t    dst;
		issue_no_t load_issue;
		int        done_before;
		wb_log.delete();
		wb_cyc_log.delete();
		grant_delay = 1;
		end_delay   = 2;
		addr  = $urandom_range(0, 255);
		a     = $urandom_range(0, addr);
		value = $urandom;
		dst   = index_t'($urandom);
		wait_idle();
		done_before  = done_count;
		cur_issue_no = next_issue;
		send(op_store, index_t'($urandom), next_issue, a, addr - a, value);
		next_issue++;
		wait_idle();
		check_eq(done_count - done_before, 1, "ls_done pulses for the store");
		check_eq(wb_log.size(), 0, "write-backs from the store");
		load_issue   = next_issue;
		cur_issue_no = next_issue;
		send(op_load, dst, load_issue, addr - a, a, 0);	// Same address, operands swapped
		next_issue++;
		while (wb_log.size() < 1) begin
			step();
		end
		wait_idle();
		check_eq(wb_log.size(), 1, "load write-back count");
		check_eq(wb_log[0], make_wb(dst, value, load_issue), "load write-back");
		check_eq(done_count - done_before, 2, "ls_done pulses for store and load");
		report("store_load");
	endtask

	task automatic wb_order();
		data_t     addr;
		data_t     a;
		data_t     x;
		data_t     y;
		data_t     exp_load;
		index_t    load_dst;
		index_t    mac_dst;
		issue_no_t load_issue;
		issue_no_t mac_issue;
		int        start;
		wb_log.delete();
		wb_cyc_log.delete();
		grant_delay = 0;	// Load result lands with the add result
		end_delay   = 0;
		addr     = $urandom_range(0, 255);
		a        = $urandom_range(0, addr);
		x        = $urandom;
		y        = $urandom;
		load_dst = index_t'($urandom);
		mac_dst  = index_t'($urandom);
		wait_idle();
		// The issue stage hands over the younger add first
		load_issue   = next_issue;
		mac_issue    = next_issue + 1;
		next_issue   = next_issue + 2;
		exp_load     = mem_array[addr[7:0]];
		cur_issue_no = mac_issue;
		start        = cycle;
		send(op_add, mac_dst, mac_issue, x, y, 0);
		send(op_load, load_dst, load_issue, a, addr - a, 0);
		while (wb_log.size() < 2) begin
			step();
		end
		repeat (4) step();
		check_eq(wb_log.size(), 2, "write-back count with conflict");
		check_eq(wb_log[0], make_wb(load_dst, exp_load, load_issue), "older load first");
		check_eq(wb_cyc_log[0], start + MAC_DEPTH, "load write-back cycle");
		check_eq(wb_log[1], make_wb(mac_dst, x + y, mac_issue), "held add second");
		check_eq(wb_cyc_log[1], start + MAC_DEPTH + 1, "held add write-back cycle");
		report("wb_order");
	endtask

	task automatic busy_drop();
		data_t     addr;
		data_t     a;
		data_t     exp_data;
		index_t    dst;
		issue_no_t first_issue;
		int        count_before;
		int        done_before;
		wb_log.delete();
		wb_cyc_log.delete();
		grant_delay = 2;
		end_delay   = 2;
		addr = $urandom_range(0, 255);
		a    = $urandom_range(0, addr);
		dst  = index_t'($urandom);
		wait_idle();
		count_before = access_count;
		done_before  = done_count;
		exp_data     = mem_array[addr[7:0]];
		first_issue  = next_issue;
		cur_issue_no = next_issue;
		send(op_load, dst, first_issue, a, addr - a, 0);
		next_issue++;
		@(negedge clock);
		check_eq(busy, 1, "busy with a load in flight");
		step();
		cur_issue_no = next_issue;
		send(op_store, index_t'($urandom), next_issue, addr ^ 8'h55, 0, $urandom);
		next_issue++;
		while (wb_log.size() < 1) begin
			step();
		end
		wait_idle();
		repeat (4) step();
		check_eq(access_count - count_before, 1, "memory accesses seen");
		check_eq(wb_log.size(), 1, "write-backs after dropped request");
		check_eq(wb_log[0], make_wb(dst, exp_data, first_issue), "first load write-back");
		check_eq(done_count - done_before, 1, "ls_done pulses");
		report("busy_drop");
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	initial begin
		void'($urandom(63));
		rst_n        = 1'b0;
		req          = 1'b0;
		cmd          = '0;
		cur_issue_no = '0;
		mem_grant    = 1'b0;
		mem_end      = 1'b0;
		mem_rdata    = '0;
		grant_delay  = 0;
		end_delay    = 0;
		access_count = 0;
		done_count   = 0;
		errors       = 0;
		checks       = 0;
		test_errors  = 0;
		next_issue   = '0;
		for (int i = 0; i < 256; i++) begin
			mem_array[i] = {8'hc3, i[7:0], ~i[7:0], i[7:0] ^ 8'h5a};	// Distinct per word
		end
		repeat (5) @(posedge clock);
		#1;
		rst_n = 1'b1;
		reset_values();
		arith_stream();
		store_load();
		wb_order();
		busy_drop();
		$display("tests 5, checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- exec_unit/exec_unit.sv
`timescale 1ns/1ps
// Execution unit of a vector lane
// Decodes issued commands into the multiply-add pipeline or the
// load/store unit and merges both result streams into one
// age-ordered write-back port

module exec_unit #(
	parameter int MAC_DEPTH = 4
)(
	input  logic                clock,
	input  logic                rst_n,
	input  logic                req,	// One-cycle issue strobe
	input  exec_pkg::exec_cmd_t cmd,
	input  exec_pkg::issue_no_t cur_issue_no,	// Newest issued command
	input  logic                mem_grant,
	input  logic                mem_end,
	input  exec_pkg::data_t     mem_rdata,
	output logic                busy,
	output logic                mem_req,
	output exec_pkg::mem_req_t  mem,
	output logic                wb_valid,
	output exec_pkg::wb_t       wb,
	output logic                ls_done
);

	import exec_pkg::*;

	logic accept;
	logic is_arith;
	logic is_mem;
	logic mac_req;
	logic ls_req;
	logic frozen;
	logic ls_busy;
	logic mac_valid;
	logic mac_ack;
	wb_t  mac_wb;
	logic ls_valid;
	logic ls_ack;
	wb_t  ls_wb;

	//////////////////////////////////////////////////
	// Request decode
	assign is_arith = (cmd.op == op_madd) | (cmd.op == op_mul) | (cmd.op == op_add);
	assign is_mem   = (cmd.op == op_load) | (cmd.op == op_store);

	assign busy    = frozen | ls_busy;	// Requests dropped while high
	assign accept  = req & ~busy;
	assign mac_req = accept & is_arith;
	assign ls_req  = accept & is_mem;

	//////////////////////////////////////////////////
	// Datapath blocks
	mac_pipe #(
		.MAC_DEPTH (MAC_DEPTH)
	) u_mac_pipe (
		.clock     (clock),
		.rst_n     (rst_n),
		.mac_req   (mac_req),
		.cmd       (cmd),
		.mac_ack   (mac_ack),
		.mac_valid (mac_valid),
		.mac_wb    (mac_wb),
		.frozen    (frozen)
	);

	ldst_unit u_ldst_unit (
		.clock     (clock),
		.rst_n     (rst_n),
		.ls_req    (ls_req),
		.cmd       (cmd),
		.mem_grant (mem_grant),
		.mem_end   (mem_end),
		.mem_rdata (mem_rdata),
		.ls_ack    (ls_ack),
		.ls_busy   (ls_busy),
		.mem_req   (mem_req),
		.mem       (mem),
		.ls_valid  (ls_valid),
		.ls_wb     (ls_wb),
		.ls_done   (ls_done)
	);

	wb_select u_wb_select (
		.cur_issue_no (cur_issue_no),
		.mac_valid    (mac_valid),
		.mac_wb       (mac_wb),
		.ls_valid     (ls_valid),
		.ls_wb        (ls_wb),
		.mac_ack      (mac_ack),
		.ls_ack       (ls_ack),
		.wb_valid     (wb_valid),
		.wb           (wb)
	);

endmodule

//--- exec_unit/ldst_unit.sv
`timescale 1ns/1ps
// Load/store sequencer
// Runs one memory access at a time: latches the command, holds
// the request until granted, waits for the end strobe and then
// either completes a store or offers the loaded word for write-back

module ldst_unit (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                ls_req,	// Accepted load or store
	input  exec_pkg::exec_cmd_t cmd,
	input  logic                mem_grant,
	input  logic                mem_end,	// Access finished
	input  exec_pkg::data_t     mem_rdata,	// Valid with mem_end
	input  logic                ls_ack,	// Write-back taken
	output logic                ls_busy,
	output logic                mem_req,
	output exec_pkg::mem_req_t  mem,
	output logic                ls_valid,
	output exec_pkg::wb_t       ls_wb,
	output logic                ls_done
);

	import exec_pkg::*;

	typedef enum logic [1:0] {
		idle     = 2'd0,
		request  = 2'd1,	// Waiting for grant
		wait_end = 2'd2,	// Access in progress
		hold_wb  = 2'd3	// Load data waiting for write-back
	} ls_state_e;

	ls_state_e state;
	ls_state_e state_nxt;
	mem_req_t  req_q;
	wb_t       wb_q;
	logic      store_end;
	logic      load_end;

	//////////////////////////////////////////////////
	// State register
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			idle: begin
				if (ls_req) begin
					state_nxt = request;
				end
			end
			request: begin
				if (mem_grant) begin
					state_nxt = wait_end;
				end
			end
			wait_end: begin
				if (mem_end) begin
					state_nxt = req_q.we ? idle : hold_wb;	// Stores finish here
				end
			end
			hold_wb: begin
				if (ls_ack) begin
					state_nxt = idle;
				end
			end
			default: state_nxt = idle;
		endcase
	end

	//////////////////////////////////////////////////
	// Command and data capture
	always_ff @(posedge clock) begin
		if (state == idle && ls_req) begin
			req_q.we       <= (cmd.op == op_store);
			req_q.addr     <= cmd.src1 + cmd.src2;	// Effective address
			req_q.wdata    <= cmd.src3;
			wb_q.dst       <= cmd.dst;
			wb_q.issue_no  <= cmd.issue_no;
		end
		if (load_end) begin
			wb_q.data <= mem_rdata;
		end
	end

	assign store_end = (state == wait_end) & mem_end & req_q.we;
	assign load_end  = (state == wait_end) & mem_end & ~req_q.we;

	//////////////////////////////////////////////////
	// Outputs
	assign ls_busy  = (state != idle);
	assign mem_req  = (state == request);
	assign mem      = req_q;
	assign ls_valid = (state == hold_wb);
	assign ls_wb    = wb_q;

	// Store ends on mem_end, load on its write-back
	assign ls_done = store_end | (ls_valid & ls_ack);

endmodule

//--- exec_unit/mac_pipe.sv
`timescale 1ns/1ps
// Multiply-add pipeline
// Stage one forms a*b or a+b, stage two adds src3 for madd and
// the remaining stages only delay the result. The whole pipe
// holds while its last stage has an unacknowledged result

module mac_pipe #(
	parameter int MAC_DEPTH = 4	// Two or more
)(
	input  logic                clock,
	input  logic                rst_n,
	input  logic                mac_req,	// Accepted arithmetic command
	input  exec_pkg::exec_cmd_t cmd,
	input  logic                mac_ack,	// Result taken this cycle
	output logic                mac_valid,
	output exec_pkg::wb_t       mac_wb,
	output logic                frozen
);

	import exec_pkg::*;

	logic [MAC_DEPTH-1:0] stg_valid;
	wb_t                  stg [MAC_DEPTH];
	logic                 advance;
	data_t                s1_result;
	data_t                s1_addend;	// src3 carried to stage two
	logic                 s1_madd;
	data_t                s2_term;

	// Move only if the output slot is empty or being drained
	assign advance = ~stg_valid[MAC_DEPTH-1] | mac_ack;
	assign frozen  = stg_valid[MAC_DEPTH-1] & ~mac_ack;

	assign mac_valid = stg_valid[MAC_DEPTH-1];
	assign mac_wb    = stg[MAC_DEPTH-1];

	//////////////////////////////////////////////////
	// Stage one arithmetic
	always_comb begin
		if (cmd.op == op_add) begin
			s1_result = cmd.src1 + cmd.src2;
		end else begin
			s1_result = cmd.src1 * cmd.src2;	// Low half of product
		end
	end

	assign s2_term = s1_madd ? s1_addend : data_t'(0);

	//////////////////////////////////////////////////
	// Valid chain
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			stg_valid <= '0;
		end else if (advance) begin
			stg_valid <= {stg_valid[MAC_DEPTH-2:0], mac_req};
		end
	end

	//////////////////////////////////////////////////
	// Payload stages
	always_ff @(posedge clock) begin
		if (advance) begin
			stg[0].dst      <= cmd.dst;
			stg[0].issue_no <= cmd.issue_no;
			stg[0].data     <= s1_result;
			s1_addend       <= cmd.src3;
			s1_madd         <= (cmd.op == op_madd);

			stg[1].dst      <= stg[0].dst;
			stg[1].issue_no <= stg[0].issue_no;
			stg[1].data     <= stg[0].data + s2_term;	// Accumulate for madd

			// Plain delay beyond stage two
			for (int k = 2; k < MAC_DEPTH; k++) begin
				stg[k] <= stg[k-1];
			end
		end
	end

endmodule

//--- exec_unit/wb_select.sv
`timescale 1ns/1ps
// Write-back selector
// Compares the wrapping ages of the two pending results and
// passes the older one to the write-back port. Ties go to the
// load/store side, the loser keeps its offer

module wb_select (
	input  exec_pkg::issue_no_t cur_issue_no,
	input  logic                mac_valid,
	input  exec_pkg::wb_t       mac_wb,
	input  logic                ls_valid,
	input  exec_pkg::wb_t       ls_wb,
	output logic                mac_ack,
	output logic                ls_ack,
	output logic                wb_valid,
	output exec_pkg::wb_t       wb
);

	import exec_pkg::*;

	issue_no_t age_mac;
	issue_no_t age_ls;
	logic      ls_older;
	logic      pick_ls;

	//////////////////////////////////////////////////
	// Age compare
	// Distance back from the newest issue number, modulo 2**ISSUE_W
	assign age_mac  = cur_issue_no - mac_wb.issue_no;
	assign age_ls   = cur_issue_no - ls_wb.issue_no;
	assign ls_older = (age_ls >= age_mac);	// Tie favours load/store

	assign pick_ls = ls_valid & (~mac_valid | ls_older);

	//////////////////////////////////////////////////
	// Grant and mux
	assign ls_ack   = pick_ls;
	assign mac_ack  = mac_valid & ~pick_ls;
	assign wb_valid = mac_valid | ls_valid;
	assign wb       = pick_ls ? ls_wb : mac_wb;

endmodule

//--- src.f
common/exec_pkg.sv
exec_unit/mac_pipe.sv
exec_unit/ldst_unit.sv
exec_unit/wb_select.sv
exec_unit/exec_unit.sv
dv/exec_unit_asserts.sv
dv/tb_exec_unit.sv
